/* tb/gpr_stimulus.txt */
# W adr data = bus write, R adr data = bus read expecting data, all hex
# S illegal count = status read, command word at adr 8 is {size32, modrm, opcode}
S 0 00
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
R 6 00000000
R 7 00000000
W 0 11223344
W 1 55667788
W 2 99aabbcc
W 3 ddeeff00
W 4 01234567
W 5 89abcdef
W 6 0badf00d
W 7 cafe1234
R 0 11223344
R 1 55667788
R 2 99aabbcc
R 3 ddeeff00
R 4 01234567
R 5 89abcdef
R 6 0badf00d
R 7 cafe1234
# mov eax ecx, mov ax cx, mov ecx eax
W 8 0001c889
R 0 55667788
W 0 11223344
W 8 0000c889
R 0 11227788
W 8 0001c88b
R 1 11227788
# mov al ah, mov bh dl
W 8 0001e088
R 0 11227777
W 8 0001fa8a
R 3 ddeecc00
# xchg ebp esp, xchg al ah, xchg eax ebx at 32 and 16 bit
W 8 0001e587
R 4 89abcdef
R 5 01234567
W 0 a1b2c3d4
W 8 0001e086
R 0 a1b2d4c3
W 8 00010093
R 0 ddeecc00
R 3 a1b2d4c3
W 8 00000093
R 0 ddeed4c3
R 3 a1b2cc00
S 0 09
# opcode 01, then mov with mod 00
W 8 0001c001
S 1 09
R 0 ddeed4c3
W 8 00010889
S 1 09
R 0 ddeed4c3
R 1 11227788
# legal mov clears the illegal bit
W 8 0001c889
S 0 0a
R 0 11227788

/* files.f */
+incdir+include
source/gpr_pkg.sv
source/decode_general_register.sv
source/instruction_field_decode.sv
source/general_register_file.sv
source/gpr_bus_slave.sv
source/gpr_unit.sv
tb/gpr_unit_tb.sv

/* run.sh */
#!/bin/sh
# build the gpr unit testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module gpr_unit_tb -o gpr_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/gpr_unit_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* tb/gpr_unit_tb.sv */
// ##############################
// gpr unit testbench
// replays wishbone operations from the
// stimulus file and checks read values
// ##############################

`timescale 1ns/10ps

`include "gpr_map.svh"

module gpr_unit_tb
    import gpr_pkg::*;
();

    localparam int    RESET_CYCLES = 8;
    localparam int    ACK_TIMEOUT  = 20;
    localparam int    ACK_LATENCY  = 2;
    localparam string STIM_FILE    = "tb/gpr_stimulus.txt";

    logic    clk;
    logic    rst_n;
    wb_req_t req;
    wb_rsp_t rsp;

    gpr_unit gpr_unit_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // fail line, then stop the run
    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input gpr_word_t got, input gpr_word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_status(input string name, input gpr_status_t got,
                                input gpr_status_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got illegal %0b count %0d expected illegal %0b count %0d",
                     $time, name, got.illegal, got.done_count, exp.illegal, exp.done_count);
            stop_with_failure();
        end
    endtask

    // one classic cycle, entered right after a falling edge
    task automatic bus_cycle(input logic we, input logic [3:0] adr,
                             input gpr_word_t wdata, output gpr_word_t rdata);
        logic seen;
        int   n;
        seen  = 1'b0;
        n     = 0;
        rdata = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdata;
        // request held until ack, ack sampled mid cycle
        while (!seen && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
            if (rsp.ack) begin
                seen  = 1'b1;
                rdata = rsp.dat;
            end
        end
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
        if (!seen) begin
            $display("no ack from the DUT within %0d cycles at address %0h", ACK_TIMEOUT, adr);
            stop_with_failure();
        end else if (n != ACK_LATENCY) begin
            $display("ERR %0t rsp.ack latency got %0d expected %0d", $time, n, ACK_LATENCY);
            stop_with_failure();
        end else begin
            // one idle cycle, ack must be gone by then
            @(negedge clk);
            if (rsp.ack !== 1'b0) begin
                $display("ERR %0t rsp.ack got %b expected %b", $time, rsp.ack, 1'b0);
                stop_with_failure();
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          ops;
        string       line;
        byte         kind;
        logic [31:0] a;
        logic [31:0] d;
        gpr_word_t   rd;
        gpr_status_t exp_status;
        gpr_status_t got_status;
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = '0;
        ops   = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            stop_with_failure();
        end else begin
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // blank lines and column notes
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h", kind, a, d);
                    if (n != 3) begin
                        $display("malformed stimulus line: %s", line);
                        stop_with_failure();
                    end
                    case (kind)
                        "W": begin
                            bus_cycle(1'b1, a[3:0], d, rd);
                        end
                        "R": begin
                            bus_cycle(1'b0, a[3:0], '0, rd);
                            check_word($sformatf("rsp.dat at adr %0h", a[3:0]), rd, d);
                        end
                        "S": begin
                            bus_cycle(1'b0, `GPR_ADR_STATUS, '0, rd);
                            got_status.illegal    = rd[`GPR_STAT_ILLEGAL];
                            got_status.done_count = rd[`GPR_STAT_COUNT_LSB +: 8];
                            exp_status.illegal    = a[0];
                            exp_status.done_count = d[7:0];
                            check_status("status", got_status, exp_status);
                            // nothing else lives in the status word
                            check_word("rsp.dat status spare bits", rd & ~32'h0000_ff01, '0);
                        end
                        default: begin
                            $display("unknown operation in stimulus line: %s", line);
                            stop_with_failure();
                        end
                    endcase
                    ops++;
                end
            end
            $fclose(fd);
            if (ops == 0) begin
                $display("the stimulus file held no operations");
                stop_with_failure();
            end else begin
                $display("%0d bus operations replayed", ops);
                $display("Finished with no errors");
                $finish;
            end
        end
    end

endmodule

/* source/gpr_unit.sv */
// ##############################
// gpr operand path top
// wishbone slave, field decode, register file
// ##############################

`timescale 1ns/10ps

module gpr_unit
    import gpr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    gpr_cmd_t  cmd;
    gpr_op_t   op;
    logic      op_we;
    logic      host_we;
    gpr_code_t host_code;
    gpr_word_t host_wdata;
    gpr_word_t host_rdata;

    gpr_bus_slave bus_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .rsp        (rsp),
        .cmd        (cmd),
        .op_legal   (op.legal),
        .op_we      (op_we),
        .host_we    (host_we),
        .host_code  (host_code),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    // combinational, settles during the busy cycle
    instruction_field_decode field_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .op    (op)
    );

    general_register_file register_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_we    (host_we),
        .host_code  (host_code),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .op         (op),
        .op_we      (op_we)
    );

endmodule

/* source/gpr_bus_slave.sv */
// ##############################
// gpr wishbone classic slave
// host register access, command latch
// and issue, status word
// ##############################

`timescale 1ns/10ps

`include "gpr_map.svh"

module gpr_bus_slave
    import gpr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  wb_req_t   req,
    output wb_rsp_t   rsp,
    output gpr_cmd_t  cmd,
    input  logic      op_legal,
    output logic      op_we,
    output logic      host_we,
    output gpr_code_t host_code,
    output gpr_word_t host_wdata,
    input  gpr_word_t host_rdata
);

    logic        busy;
    logic        ack_q;
    logic [31:0] rdata_q;
    logic        start;
    logic        cmd_hit;
    logic        status_hit;
    logic        reg_hit;
    logic [3:0]  reg_off;
    logic        cmd_issue;
    gpr_status_t status_q;
    logic [31:0] status_word;

    // new request only when idle and not in the ack cycle
    assign start = req.cyc & req.stb & ~busy & ~ack_q;

    assign reg_off    = req.adr - `GPR_ADR_REG0;
    assign reg_hit    = ~reg_off[3];
    assign cmd_hit    = (req.adr == `GPR_ADR_CMD);
    assign status_hit = (req.adr == `GPR_ADR_STATUS);

    assign host_code  = reg_off[2:0];
    assign host_wdata = req.dat;

    // writes land on the edge that raises ack
    assign host_we   = busy & req.we & reg_hit;
    assign cmd_issue = busy & req.we & cmd_hit;
    assign op_we     = cmd_issue & op_legal;

    always_comb begin
        status_word = '0;
        status_word[`GPR_STAT_ILLEGAL] = status_q.illegal;
        status_word[`GPR_STAT_COUNT_LSB +: 8] = status_q.done_count;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            ack_q    <= 1'b0;
            status_q <= '0;
        end else begin
            // ack one cycle after the sampling edge, one cycle wide
            busy  <= start;
            ack_q <= busy;
            if (cmd_issue) begin
                // rejected command keeps the count
                status_q.illegal <= ~op_legal;
                if (op_legal)
                    status_q.done_count <= status_q.done_count + 8'd1;
            end
        end
    end

    // command latched at the sampling edge, stable through the issue edge
    always_ff @(posedge clk) begin
        if (start && req.we && cmd_hit)
            cmd <= gpr_cmd_t'(req.dat[16:0]);
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            if (reg_hit)
                rdata_q <= host_rdata;
            else if (status_hit)
                rdata_q <= status_word;
            else if (cmd_hit)
                rdata_q <= {15'h0000, cmd};
            else
                rdata_q <= '0;
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = rdata_q;

    // ack answers a request held through the busy cycle
    a_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.ack |-> $past(req.cyc && req.stb));

endmodule

/* source/general_register_file.sv */
// ##############################
// general register file
// eight 32-bit registers, host word access,
// lane-merging mov and xchg writes
// ##############################

`timescale 1ns/10ps

module general_register_file
    import gpr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      host_we,
    input  gpr_code_t host_code,
    input  gpr_word_t host_wdata,
    output gpr_word_t host_rdata,
    input  gpr_op_t   op,
    input  logic      op_we
);

    localparam gpr_word_t HIGH_BYTE = 32'h0000_ff00;

    gpr_word_t regs      [8];
    gpr_word_t regs_next [8];
    gpr_word_t dst_val;
    gpr_word_t src_val;

    // lane of register idx covered by a select
    function automatic gpr_word_t lane_mask(gpr_sel_t sel, gpr_code_t idx);
        gpr_word_t m;
        m = '0;
        if (sel.dword_sel[idx])
            m = 32'hffff_ffff;
        if (sel.word_sel[idx])
            m = 32'h0000_ffff;
        // byte codes 0 to 3 low lane, 4 to 7 high lane of regs 0 to 3
        if (!idx[2] && sel.byte_sel[idx])
            m = 32'h0000_00ff;
        if (!idx[2] && sel.byte_sel[{1'b1, idx[1:0]}])
            m = HIGH_BYTE;
        return m;
    endfunction

    // selected lane, shifted down and zero extended
    function automatic gpr_word_t read_lane(gpr_sel_t sel);
        gpr_word_t val;
        gpr_word_t m;
        val = '0;
        for (int i = 0; i < 8; i++) begin
            m = lane_mask(sel, gpr_code_t'(i));
            if (m == HIGH_BYTE)
                val |= (regs[i] & m) >> 8;
            else
                val |= regs[i] & m;
        end
        return val;
    endfunction

    // value placed into its lane, rest of the register kept
    function automatic gpr_word_t lane_merge(gpr_word_t cur, gpr_word_t m, gpr_word_t value);
        gpr_word_t placed;
        placed = (m == HIGH_BYTE) ? {16'h0000, value[7:0], 8'h00} : value;
        return (cur & ~m) | (placed & m);
    endfunction

    assign host_rdata = regs[host_code];

    // lane-aligned operand values, follow both the selects and the registers
    always_comb begin
        dst_val = read_lane(op.dst_sel);
        src_val = read_lane(op.src_sel);
    end

    always_comb begin
        regs_next = regs;
        if (host_we) begin
            regs_next[host_code] = host_wdata;
        end else if (op_we) begin
            for (int i = 0; i < 8; i++) begin
                // xchg half first, so xchg al,ah merges both lanes
                if (op.swap)
                    regs_next[i] = lane_merge(regs_next[i],
                                              lane_mask(op.src_sel, gpr_code_t'(i)), dst_val);
                regs_next[i] = lane_merge(regs_next[i],
                                          lane_mask(op.dst_sel, gpr_code_t'(i)), src_val);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else begin
            regs <= regs_next;
        end
    end

    // host access and command write share the bus, never together
    a_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_we && op_we));

    // slave writes only ops the field decode accepted
    a_we_legal: assert property (@(posedge clk) disable iff (!rst_n)
        op_we |-> op.legal);

endmodule

/* source/instruction_field_decode.sv */
// ##############################
// instruction field decode
// opcode and modrm split, legality check,
// destination and source register selects
// ##############################

`timescale 1ns/10ps

module instruction_field_decode
    import gpr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  gpr_cmd_t cmd,
    output gpr_op_t  op
);

    logic [1:0] mod_field;
    gpr_code_t  reg_field;
    gpr_code_t  rm_field;
    gpr_code_t  dst_code;
    gpr_code_t  src_code;
    logic       w_is_present;

    assign mod_field = cmd.modrm[7:6];
    assign reg_field = cmd.modrm[5:3];
    assign rm_field  = cmd.modrm[2:0];

    always_comb begin
        // defaults, mov with r/m as destination
        dst_code     = rm_field;
        src_code     = reg_field;
        w_is_present = 1'b1;
        op.swap      = 1'b0;
        op.legal     = 1'b0;
        case (cmd.opcode) inside
            8'h88, 8'h89, 8'h8a, 8'h8b: begin
                // only register form, no memory operand
                op.legal = (mod_field == 2'b11);
                // d bit set, reg field is the destination
                if (cmd.opcode[1]) begin
                    dst_code = reg_field;
                    src_code = rm_field;
                end
            end
            8'h86, 8'h87: begin
                op.legal = (mod_field == 2'b11);
                op.swap  = 1'b1;
            end
            [8'h90:8'h97]: begin
                // xchg with accumulator, register in opcode low bits
                dst_code     = 3'd0;
                src_code     = cmd.opcode[2:0];
                w_is_present = 1'b0;
                op.swap      = 1'b1;
                op.legal     = 1'b1;
            end
            default: op.legal = 1'b0;
        endcase
    end

    // w is opcode bit 0 for the 88 to 8b and 86 87 rows
    decode_general_register dst_decode (
        .instruction_reg (dst_code),
        .bit_width_16    (~cmd.size32),
        .bit_width_32    (cmd.size32),
        .w_is_present    (w_is_present),
        .w               (cmd.opcode[0]),
        .sel             (op.dst_sel)
    );

    decode_general_register src_decode (
        .instruction_reg (src_code),
        .bit_width_16    (~cmd.size32),
        .bit_width_32    (cmd.size32),
        .w_is_present    (w_is_present),
        .w               (cmd.opcode[0]),
        .sel             (op.src_sel)
    );

    // a legal op names at most one register view per operand
    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        op.legal |-> ($onehot0(op.dst_sel) && $onehot0(op.src_sel)));

endmodule

/* source/decode_general_register.sv */
// ##############################
// general register decode
// 3-bit reg code, operand size and w field
// to one-hot byte, word or dword select
// ##############################

`timescale 1ns/10ps

module decode_general_register
    import gpr_pkg::*;
(
    input  gpr_code_t instruction_reg,
    input  logic      bit_width_16,
    input  logic      bit_width_32,
    input  logic      w_is_present,
    input  logic      w,
    output gpr_sel_t  sel
);

    logic [7:0] code_hot;
    logic       any_width;
    logic       byte_view;
    logic       full_view;

    // one bit per register code, in 80386 code order
    assign code_hot = 8'b0000_0001 << instruction_reg;

    // some operand size must be active
    assign any_width = bit_width_16 | bit_width_32;

    // w present and clear picks the byte view at either size
    assign byte_view = w_is_present & ~w;

    // no w field, or w set, picks word or dword
    assign full_view = ~byte_view;

    // codes 4 to 7 are ah ch dh bh in the byte view
    assign sel.byte_sel = (byte_view && any_width) ? code_hot : 8'h00;

    // sp bp si di share codes with the high bytes
    assign sel.word_sel = (full_view && bit_width_16) ? code_hot : 8'h00;

    assign sel.dword_sel = (full_view && bit_width_32) ? code_hot : 8'h00;

endmodule

/* source/gpr_pkg.sv */
// ##############################
// gpr operand path types
// register values, one-hot selects, decoded
// instruction fields, status and wishbone bus
// ##############################

package gpr_pkg;

    // one general register
    typedef logic [31:0] gpr_word_t;

    // reg or r/m field, or opcode low bits
    typedef logic [2:0] gpr_code_t;

    // one-hot register views, at most one bit set overall
    typedef struct packed {
        logic [7:0] byte_sel;   // al cl dl bl ah ch dh bh
        logic [7:0] word_sel;   // ax cx dx bx sp bp si di
        logic [7:0] dword_sel;  // eax ecx edx ebx esp ebp esi edi
    } gpr_sel_t;

    // instruction word as written by the host
    typedef struct packed {
        logic       size32;     // clear means 16-bit operand size
        logic [7:0] modrm;
        logic [7:0] opcode;
    } gpr_cmd_t;

    // decoded operation for the register file
    typedef struct packed {
        gpr_sel_t dst_sel;
        gpr_sel_t src_sel;
        logic     swap;         // xchg, both operands written
        logic     legal;
    } gpr_op_t;

    typedef struct packed {
        logic       illegal;    // last command rejected
        logic [7:0] done_count;
    } gpr_status_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;       // word address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

/* include/gpr_map.svh */
// ##############################
// gpr unit wishbone address map
// and status word bit positions
// ##############################

`ifndef GPR_MAP_SVH
`define GPR_MAP_SVH

// registers 0 to 7 in code order
`define GPR_ADR_REG0   4'h0
`define GPR_ADR_CMD    4'h8
`define GPR_ADR_STATUS 4'h9

`define GPR_STAT_ILLEGAL   0
`define GPR_STAT_COUNT_LSB 8

`endif
